/* logic/clock_pkg.sv */
/*
 * Shared types and constants for the six-digit clock.
 * Segment bits run a..g from bit 6 down to bit 0, and a lit segment is 1.
 */
package clock_pkg;

	typedef enum logic [1:0] {
		MODE_CLOCK = 2'd0,
		MODE_SETUP = 2'd1,
		MODE_ALARM = 2'd2
	} mode_e;

	typedef enum logic [1:0] {
		FIELD_SEC  = 2'd0,
		FIELD_MIN  = 2'd1,
		FIELD_HOUR = 2'd2
	} field_e;

	localparam int HMS_W      = 6;
	localparam int SEC_MAX    = 59;		// seconds and minutes
	localparam int HOUR_MAX   = 23;
	localparam int TICK_DIV   = 50_000_000;	// clk cycles per second
	localparam int SCAN_DIV   = 5_000;	// clk cycles per scan step
	localparam int NUM_DIGITS = 6;
	localparam int SEG_W      = 7;
	localparam int ALARM_SECS = 5;	// ring length in seconds

	function automatic logic [SEG_W-1:0] seg_of_digit(input logic [3:0] digit);
		case (digit)
			4'd0:    return 7'b111_1110;
			4'd1:    return 7'b011_0000;
			4'd2:    return 7'b110_1101;
			4'd3:    return 7'b111_1001;
			4'd4:    return 7'b011_0011;
			4'd5:    return 7'b101_1011;
			4'd6:    return 7'b101_1111;
			4'd7:    return 7'b111_0000;
			4'd8:    return 7'b111_1111;
			4'd9:    return 7'b111_0011;
			default: return 7'b000_0000;	// blank
		endcase
	endfunction

endpackage

/* logic/tick_gen.sv */
/*
 * Second and digit-scan enables, one clk cycle wide.
 * Both dividers must be at least 2.
 */
`timescale 1ns/1ps
module tick_gen import clock_pkg::*; #(
	parameter int TICK_DIV = clock_pkg::TICK_DIV,
	parameter int SCAN_DIV = clock_pkg::SCAN_DIV
) (
	input  logic clk,
	input  logic rst_n,
	output logic o_sec_tick,
	output logic o_scan_tick
);

	localparam int TICK_CW = $clog2(TICK_DIV);
	localparam int SCAN_CW = $clog2(SCAN_DIV);

	logic [TICK_CW-1:0] sec_cnt;
	logic [SCAN_CW-1:0] scan_cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sec_cnt     <= TICK_CW'(TICK_DIV - 1);
			scan_cnt    <= SCAN_CW'(SCAN_DIV - 1);
			o_sec_tick  <= 1'b0;
			o_scan_tick <= 1'b0;
		end else begin
			o_sec_tick  <= (sec_cnt == '0);
			o_scan_tick <= (scan_cnt == '0);
			sec_cnt  <= (sec_cnt == '0) ? TICK_CW'(TICK_DIV - 1) : sec_cnt - 1'b1;
			scan_cnt <= (scan_cnt == '0) ? SCAN_CW'(SCAN_DIV - 1) : scan_cnt - 1'b1;
		end
	end

	// the counters drive a single-cycle enable, never a level
	a_sec_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		o_sec_tick |=> !o_sec_tick);

endmodule

/* logic/mode_ctrl.sv */
/*
 * Buttons are active high and assumed bounce free.
 * A press needs 3 high cycles and 3 low cycles before the next one.
 */
`timescale 1ns/1ps
module mode_ctrl import clock_pkg::*; (
	input  logic   clk,
	input  logic   rst_n,
	input  logic   i_btn_mode,
	input  logic   i_btn_field,
	input  logic   i_btn_inc,
	input  logic   i_btn_alarm,
	output mode_e  o_mode,
	output field_e o_field,
	output logic   o_alarm_en,
	output logic   o_run,
	output logic   o_clk_inc_sec,
	output logic   o_clk_inc_min,
	output logic   o_clk_inc_hour,
	output logic   o_alm_inc_sec,
	output logic   o_alm_inc_min,
	output logic   o_alm_inc_hour
);

	logic [3:0] sync_1;
	logic [3:0] sync_2;
	logic [3:0] sync_3;	// previous synced level, for edges
	logic       mode_rise;
	logic       field_rise;
	logic       inc_rise;
	logic       alarm_rise;
	logic       inc_clk;
	logic       inc_alm;

	// -------------------------------------------------------------------------
	// synchronizer and rising edge
	// -------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sync_1 <= '0;
			sync_2 <= '0;
			sync_3 <= '0;
		end else begin
			sync_1 <= {i_btn_alarm, i_btn_inc, i_btn_field, i_btn_mode};
			sync_2 <= sync_1;
			sync_3 <= sync_2;
		end
	end

	assign {alarm_rise, inc_rise, field_rise, mode_rise} = sync_2 & ~sync_3;

	// -------------------------------------------------------------------------
	// mode / field state
	// -------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_mode     <= MODE_CLOCK;
			o_field    <= FIELD_SEC;
			o_alarm_en <= 1'b0;
		end else begin
			if (mode_rise)
				o_mode <= (o_mode == MODE_ALARM) ? MODE_CLOCK : mode_e'(o_mode + 2'd1);
			if (field_rise)
				o_field <= (o_field == FIELD_HOUR) ? FIELD_SEC : field_e'(o_field + 2'd1);
			if (alarm_rise)
				o_alarm_en <= ~o_alarm_en;
		end
	end

	assign o_run = (o_mode != MODE_SETUP);	// clock stands still while set

	// increment goes to whichever counter the mode edits
	assign inc_clk = inc_rise && (o_mode == MODE_SETUP);
	assign inc_alm = inc_rise && (o_mode == MODE_ALARM);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_clk_inc_sec  <= 1'b0;
			o_clk_inc_min  <= 1'b0;
			o_clk_inc_hour <= 1'b0;
			o_alm_inc_sec  <= 1'b0;
			o_alm_inc_min  <= 1'b0;
			o_alm_inc_hour <= 1'b0;
		end else begin
			o_clk_inc_sec  <= inc_clk && (o_field == FIELD_SEC);
			o_clk_inc_min  <= inc_clk && (o_field == FIELD_MIN);
			o_clk_inc_hour <= inc_clk && (o_field == FIELD_HOUR);
			o_alm_inc_sec  <= inc_alm && (o_field == FIELD_SEC);
			o_alm_inc_min  <= inc_alm && (o_field == FIELD_MIN);
			o_alm_inc_hour <= inc_alm && (o_field == FIELD_HOUR);
		end
	end

	a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({o_clk_inc_sec, o_clk_inc_min, o_clk_inc_hour,
			o_alm_inc_sec, o_alm_inc_min, o_alm_inc_hour}));

endmodule

/* logic/hms_counter.sv */
/*
 * Running ticks carry sec -> min -> hour, increments wrap one field only.
 * Tie i_run low for a counter that is only ever set by hand.
 */
`timescale 1ns/1ps
module hms_counter import clock_pkg::*; (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             i_tick,
	input  logic             i_run,
	input  logic             i_inc_sec,
	input  logic             i_inc_min,
	input  logic             i_inc_hour,
	output logic [HMS_W-1:0] o_sec,
	output logic [HMS_W-1:0] o_min,
	output logic [HMS_W-1:0] o_hour
);

	logic run_tick;
	logic sec_carry;
	logic min_carry;

	// step by one, back to zero past the last value
	function automatic logic [HMS_W-1:0] wrap_inc(
		input logic [HMS_W-1:0] v,
		input logic [HMS_W-1:0] last
	);
		return (v == last) ? '0 : v + 1'b1;
	endfunction

	assign run_tick  = i_tick & i_run;
	assign sec_carry = run_tick & (o_sec == HMS_W'(SEC_MAX));
	assign min_carry = sec_carry & (o_min == HMS_W'(SEC_MAX));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_sec  <= '0;
			o_min  <= '0;
			o_hour <= '0;
		end else begin
			if (run_tick || i_inc_sec)
				o_sec <= wrap_inc(o_sec, HMS_W'(SEC_MAX));
			if (sec_carry || i_inc_min)
				o_min <= wrap_inc(o_min, HMS_W'(SEC_MAX));
			if (min_carry || i_inc_hour)	// 23:59:59 rolls to 00:00:00
				o_hour <= wrap_inc(o_hour, HMS_W'(HOUR_MAX));
		end
	end

	a_sec_range: assert property (@(posedge clk) disable iff (!rst_n)
		o_sec <= HMS_W'(SEC_MAX));
	a_min_range: assert property (@(posedge clk) disable iff (!rst_n)
		o_min <= HMS_W'(SEC_MAX));
	a_hour_range: assert property (@(posedge clk) disable iff (!rst_n)
		o_hour <= HMS_W'(HOUR_MAX));

endmodule

/* logic/alarm_unit.sv */
/*
 * Rings for ALARM_SECS second ticks once the clock reaches the alarm time.
 * A match must be left and entered again before it rings a second time.
 */
`timescale 1ns/1ps
module alarm_unit import clock_pkg::*; (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             i_sec_tick,
	input  logic             i_alarm_en,
	input  logic [HMS_W-1:0] i_sec,
	input  logic [HMS_W-1:0] i_min,
	input  logic [HMS_W-1:0] i_hour,
	input  logic [HMS_W-1:0] i_alm_sec,
	input  logic [HMS_W-1:0] i_alm_min,
	input  logic [HMS_W-1:0] i_alm_hour,
	output logic             o_alarm
);

	localparam int RING_W = $clog2(ALARM_SECS);

	logic              time_eq;
	logic              armed;	// set once the clock is off the match
	logic [RING_W-1:0] ring_cnt;

	assign time_eq = (i_sec == i_alm_sec) && (i_min == i_alm_min) && (i_hour == i_alm_hour);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_alarm  <= 1'b0;
			armed    <= 1'b1;
			ring_cnt <= '0;
		end else begin
			if (!time_eq)
				armed <= 1'b1;

			if (!i_alarm_en) begin
				o_alarm  <= 1'b0;
				ring_cnt <= '0;
			end else if (!o_alarm) begin
				if (time_eq && armed) begin	// first cycle of a match
					o_alarm  <= 1'b1;
					armed    <= 1'b0;
					ring_cnt <= '0;
				end
			end else if (i_sec_tick) begin
				if (ring_cnt == RING_W'(ALARM_SECS - 1)) begin
					o_alarm  <= 1'b0;
					ring_cnt <= '0;
				end else begin
					ring_cnt <= ring_cnt + 1'b1;
				end
			end
		end
	end

	a_quiet_when_off: assert property (@(posedge clk) disable iff (!rst_n)
		!$past(i_alarm_en) |-> !o_alarm);

endmodule

/* logic/display_scan.sv */
/*
 * Digit 0 is the seconds units, digit 5 the hours tens.
 * o_seg_enb is active low, o_seg and o_seg_dp are active high.
 */
`timescale 1ns/1ps
module display_scan import clock_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  i_scan_tick,
	input  logic                  i_alarm_en,
	input  mode_e                 i_mode,
	input  logic [HMS_W-1:0]      i_sec,
	input  logic [HMS_W-1:0]      i_min,
	input  logic [HMS_W-1:0]      i_hour,
	output logic [SEG_W-1:0]      o_seg,
	output logic                  o_seg_dp,
	output logic [NUM_DIGITS-1:0] o_seg_enb
);

	localparam int DIG_W = $clog2(NUM_DIGITS);

	logic [DIG_W-1:0] digit;
	logic [DIG_W-1:0] digit_nxt;
	logic [3:0]       cur_val;
	logic             cur_dp;

	assign digit_nxt = !i_scan_tick ? digit :
		(digit == DIG_W'(NUM_DIGITS - 1)) ? '0 : digit + 1'b1;

	// tens / units of the digit about to be shown
	always_comb begin
		case (digit_nxt)
			3'd0:    cur_val = 4'(i_sec % 10);
			3'd1:    cur_val = 4'(i_sec / 10);
			3'd2:    cur_val = 4'(i_min % 10);
			3'd3:    cur_val = 4'(i_min / 10);
			3'd4:    cur_val = 4'(i_hour % 10);
			3'd5:    cur_val = 4'(i_hour / 10);
			default: cur_val = 4'hf;	// blank
		endcase
	end

	// mode point, plus the last digit while the alarm is armed
	assign cur_dp = (digit_nxt == DIG_W'(i_mode)) ||
		((digit_nxt == DIG_W'(NUM_DIGITS - 1)) && i_alarm_en);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			digit     <= '0;
			o_seg     <= '0;
			o_seg_dp  <= 1'b0;
			o_seg_enb <= ~NUM_DIGITS'(1);
		end else begin
			digit     <= digit_nxt;
			o_seg     <= seg_of_digit(cur_val);
			o_seg_dp  <= cur_dp;
			o_seg_enb <= ~(NUM_DIGITS'(1) << digit_nxt);
		end
	end

endmodule

/* logic/clock_top.sv */
/*
 * Six-digit clock with alarm on a single clk.
 * The display shows the alarm time in alarm mode, the clock time otherwise.
 */
`timescale 1ns/1ps
module clock_top import clock_pkg::*; #(
	parameter int TICK_DIV = clock_pkg::TICK_DIV,
	parameter int SCAN_DIV = clock_pkg::SCAN_DIV
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  i_btn_mode,
	input  logic                  i_btn_field,
	input  logic                  i_btn_inc,
	input  logic                  i_btn_alarm,
	output logic [SEG_W-1:0]      o_seg,
	output logic                  o_seg_dp,
	output logic [NUM_DIGITS-1:0] o_seg_enb,
	output logic                  o_alarm
);

	logic             sec_tick;
	logic             scan_tick;
	mode_e            mode;
	logic             alarm_en;
	logic             run;
	logic             clk_inc_sec;
	logic             clk_inc_min;
	logic             clk_inc_hour;
	logic             alm_inc_sec;
	logic             alm_inc_min;
	logic             alm_inc_hour;
	logic [HMS_W-1:0] sec;
	logic [HMS_W-1:0] min;
	logic [HMS_W-1:0] hour;
	logic [HMS_W-1:0] alm_sec;
	logic [HMS_W-1:0] alm_min;
	logic [HMS_W-1:0] alm_hour;
	logic [HMS_W-1:0] disp_sec;
	logic [HMS_W-1:0] disp_min;
	logic [HMS_W-1:0] disp_hour;

	tick_gen #(.TICK_DIV(TICK_DIV), .SCAN_DIV(SCAN_DIV)) u_tick (
		.clk(clk), .rst_n(rst_n), .o_sec_tick(sec_tick), .o_scan_tick(scan_tick));

	mode_ctrl u_mode (
		.clk(clk), .rst_n(rst_n),
		.i_btn_mode(i_btn_mode), .i_btn_field(i_btn_field),
		.i_btn_inc(i_btn_inc), .i_btn_alarm(i_btn_alarm),
		.o_mode(mode), .o_field(), .o_alarm_en(alarm_en), .o_run(run),	// field stays inside
		.o_clk_inc_sec(clk_inc_sec), .o_clk_inc_min(clk_inc_min),
		.o_clk_inc_hour(clk_inc_hour), .o_alm_inc_sec(alm_inc_sec),
		.o_alm_inc_min(alm_inc_min), .o_alm_inc_hour(alm_inc_hour));

	hms_counter clock_cnt (
		.clk(clk), .rst_n(rst_n), .i_tick(sec_tick), .i_run(run),
		.i_inc_sec(clk_inc_sec), .i_inc_min(clk_inc_min), .i_inc_hour(clk_inc_hour),
		.o_sec(sec), .o_min(min), .o_hour(hour));

	hms_counter alarm_cnt (
		.clk(clk), .rst_n(rst_n), .i_tick(sec_tick), .i_run(1'b0),	// set by hand only
		.i_inc_sec(alm_inc_sec), .i_inc_min(alm_inc_min), .i_inc_hour(alm_inc_hour),
		.o_sec(alm_sec), .o_min(alm_min), .o_hour(alm_hour));

	alarm_unit u_alarm (
		.clk(clk), .rst_n(rst_n), .i_sec_tick(sec_tick), .i_alarm_en(alarm_en),
		.i_sec(sec), .i_min(min), .i_hour(hour),
		.i_alm_sec(alm_sec), .i_alm_min(alm_min), .i_alm_hour(alm_hour),
		.o_alarm(o_alarm));

	always_comb begin
		if (mode == MODE_ALARM) begin
			disp_sec  = alm_sec;
			disp_min  = alm_min;
			disp_hour = alm_hour;
		end else begin
			disp_sec  = sec;
			disp_min  = min;
			disp_hour = hour;
		end
	end

	display_scan u_disp (
		.clk(clk), .rst_n(rst_n), .i_scan_tick(scan_tick), .i_alarm_en(alarm_en),
		.i_mode(mode), .i_sec(disp_sec), .i_min(disp_min), .i_hour(disp_hour),
		.o_seg(o_seg), .o_seg_dp(o_seg_dp), .o_seg_enb(o_seg_enb));

endmodule

/* dv/tb_clk_gen.sv */
/*
 * 20 ns testbench clock, reset held low for two rising edges.
 */
`timescale 1ns/1ps
module tb_clk_gen (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (2) @(posedge clk);
		#2 rst_n = 1'b1;	// released off the edge
	end

endmodule

/* dv/clock_tb.sv */
/*
 * Directed tests for clock_top with TICK_DIV 40 and SCAN_DIV 2.
 * The display is decoded with a local segment table, times are hhmmss ints.
 */
`timescale 1ns/1ps
module clock_tb;

	localparam int TICK  = 40;
	localparam int LIMIT = 12_000;	// cycles, about 1.5x the summed tests
	localparam int ALM_S = 15;	// alarm seconds set in test 4
	localparam int RING  = 5;	// second ticks the alarm rings for

	logic       clk, rst_n;
	logic       btn_mode, btn_field, btn_inc, btn_alarm;
	logic [6:0] seg;
	logic       seg_dp, alarm;
	logic [5:0] seg_enb;
	int         cyc, errors, tests, failed_tests, cur_field;

	tb_clk_gen clk_gen_i (.clk(clk), .rst_n(rst_n));

	clock_top #(.TICK_DIV(40), .SCAN_DIV(2)) dut_i (
		.clk(clk), .rst_n(rst_n), .i_btn_mode(btn_mode), .i_btn_field(btn_field),
		.i_btn_inc(btn_inc), .i_btn_alarm(btn_alarm), .o_seg(seg), .o_seg_dp(seg_dp),
		.o_seg_enb(seg_enb), .o_alarm(alarm));

	always @(posedge clk) begin
		if (rst_n)
			cyc <= cyc + 1;
		if (cyc >= LIMIT) begin
			$display("timeout: run did not end within %0d cycles", LIMIT);
			$display("Simulation FAILED");
			$finish;
		end
	end

	// ---------------------------------------------------------------------------
	// helpers
	// ---------------------------------------------------------------------------
	function automatic int decode_seg(input logic [6:0] s);
		case (s)
			7'b111_1110: return 0;
			7'b011_0000: return 1;
			7'b110_1101: return 2;
			7'b111_1001: return 3;
			7'b011_0011: return 4;
			7'b101_1011: return 5;
			7'b101_1111: return 6;
			7'b111_0000: return 7;
			7'b111_1111: return 8;
			7'b111_0011: return 9;
			default:     return 99;	// shows up as a bad time
		endcase
	endfunction

	task automatic check_val(input string name, input int exp, input int act);
		assert (exp == act) else begin
			$display("[FAIL] %s expected %0d actual %0d", name, exp, act);
			errors++;
		end
	endtask

	// one full scan, digit 0 first
	task automatic read_display(output int t, output logic [5:0] dp);
		int dig [6];
		for (int d = 0; d < 6; d++) begin
			@(negedge clk);
			while (seg_enb != ~(6'b1 << d))
				@(negedge clk);
			dig[d] = decode_seg(seg);
			dp[d]  = seg_dp;
		end
		t = (dig[5] * 10 + dig[4]) * 10000 + (dig[3] * 10 + dig[2]) * 100 + dig[1] * 10 + dig[0];
	endtask

	// just after a second tick has landed in the counters
	task automatic wait_window();
		@(negedge clk);
		while (cyc % TICK != 3)
			@(negedge clk);
	endtask

	task automatic press_button(input int which);
		@(posedge clk);
		#2;
		case (which)
			0: btn_mode = 1'b1;
			1: btn_field = 1'b1;
			2: btn_inc = 1'b1;
			default: btn_alarm = 1'b1;
		endcase
		repeat (3) @(posedge clk);
		#2;
		{btn_mode, btn_field, btn_inc, btn_alarm} = '0;
		repeat (4) @(posedge clk);
	endtask

	task automatic end_test(input string name, input int err_before);
		tests++;
		if (errors == err_before) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: failed", name);
			failed_tests++;
		end
	endtask

	// ---------------------------------------------------------------------------
	// tests
	// ---------------------------------------------------------------------------
	task automatic test_reset();
		int t, e;
		logic [5:0] dp;
		e = errors;
		@(posedge clk);	// display registers load on the first edge
		read_display(t, dp);
		check_val("reset time", 0, t);
		check_val("reset dp", 6'b000001, dp);
		check_val("reset alarm", 0, alarm);
		end_test("reset", e);
	endtask

	task automatic test_count();
		int t, e;
		logic [5:0] dp;
		e = errors;
		while (cyc < 61 * TICK + 3)
			@(negedge clk);
		read_display(t, dp);
		check_val("count 61 s", 101, t);
		end_test("count", e);
	endtask

	task automatic test_setup();
		int t, e;
		logic [5:0] dp;
		e = errors;
		press_button(0);
		wait_window();
		read_display(t, dp);
		check_val("setup dp", 6'b000010, dp);
		repeat (59 - t % 100) press_button(2);
		press_button(1);
		repeat (59 - (t / 100) % 100) press_button(2);
		press_button(1);
		repeat (23 - t / 10000) press_button(2);
		cur_field = 2;
		wait_window();
		read_display(t, dp);
		check_val("setup 23:59:59", 235959, t);
		repeat (2 * TICK) @(negedge clk);
		wait_window();
		read_display(t, dp);
		check_val("setup frozen", 235959, t);
		wait_window();
		press_button(0);	// through alarm mode, back to clock
		press_button(0);
		wait_window();
		read_display(t, dp);
		check_val("full wrap", 0, t);
		check_val("clock dp", 6'b000001, dp);
		end_test("setup", e);
	endtask

	task automatic test_alarm_set();
		int t, e;
		logic [5:0] dp;
		e = errors;
		press_button(0);
		press_button(0);
		while (cur_field != 0) begin
			press_button(1);
			cur_field = (cur_field + 1) % 3;
		end
		repeat (ALM_S) press_button(2);
		wait_window();
		read_display(t, dp);
		check_val("alarm time", ALM_S, t);
		check_val("alarm mode dp", 6'b000100, dp);
		press_button(3);
		wait_window();
		read_display(t, dp);
		check_val("alarm enabled dp", 6'b100100, dp);
		press_button(0);
		end_test("alarm set", e);
	endtask

	task automatic test_alarm_ring();
		int t, e, n, ticks;
		logic [5:0] dp;
		e = errors;
		wait_window();
		read_display(t, dp);
		assert (t < ALM_S) else begin
			$display("clock already past the alarm time before the ring test");
			errors++;
		end
		n = 0;
		while (!alarm && n < 30 * TICK) begin
			@(negedge clk);
			n++;
		end
		assert (alarm) else begin
			$display("alarm output never rose");
			errors++;
		end
		read_display(t, dp);
		check_val("ring time", ALM_S, t);
		ticks = 0;
		n = 0;
		while (alarm && n < (RING + 1) * TICK) begin
			if (cyc % TICK == 0)
				ticks++;
			@(negedge clk);
			n++;
		end
		assert (!alarm) else begin
			$display("alarm output never cleared");
			errors++;
		end
		check_val("ring ticks", RING, ticks);
		end_test("alarm ring", e);
	endtask

	task automatic test_alarm_off();
		int t, e, target, stop;
		logic [5:0] dp;
		e = errors;
		wait_window();
		read_display(t, dp);
		target = t % 100 + 10;
		press_button(0);
		press_button(0);
		press_button(3);
		repeat (target - ALM_S) press_button(2);	// field is still seconds
		press_button(0);
		wait_window();
		read_display(t, dp);
		check_val("disabled dp", 6'b000001, dp);
		stop = cyc + (target + 2 - t % 100) * TICK;
		while (cyc < stop) begin
			@(negedge clk);
			assert (!alarm) else begin
				$display("alarm rang while disabled");
				errors++;
			end
		end
		wait_window();
		read_display(t, dp);
		assert (t % 100 > target) else begin
			$display("clock did not pass the alarm time");
			errors++;
		end
		end_test("alarm off", e);
	endtask

	initial begin
		{btn_mode, btn_field, btn_inc, btn_alarm} = '0;
		errors       = 0;
		tests        = 0;
		failed_tests = 0;
		cur_field    = 0;
		@(posedge rst_n);
		test_reset();
		test_count();
		test_setup();
		test_alarm_set();
		test_alarm_ring();
		test_alarm_off();
		$display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

/* filelist.f */
logic/clock_pkg.sv
logic/tick_gen.sv
logic/mode_ctrl.sv
logic/hms_counter.sv
logic/alarm_unit.sv
logic/display_scan.sv
logic/clock_top.sv
dv/tb_clk_gen.sv
dv/clock_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the clock testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module clock_tb -f filelist.f -o clock_sim

./obj_dir/clock_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation PASSED" sim.log; then
	exit 0
fi
exit 1
